/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_alu_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation finished: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* alu_checker.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ALU_ADDR_W-1:0] paddr,
    input  logic [`ALU_DATA_W-1:0] prdata,
    input  logic                   pready,
    input  logic                   pslverr,
    input  logic                   exp_valid,     // Current transfer is checked
    input  logic [`ALU_DATA_W-1:0] exp_data,
    input  logic                   exp_err,
    output int                     checks,
    output int                     errors
);

    function automatic string reg_name(input logic [`ALU_ADDR_W-1:0] addr);
        case (addr)
            `ALU_REG_OPA:    return "OPA";
            `ALU_REG_OPB:    return "OPB";
            `ALU_REG_CTRL:   return "CTRL";
            `ALU_REG_CMD:    return "CMD";
            `ALU_REG_RESULT: return "RESULT";
            `ALU_REG_HI:     return "HI";
            `ALU_REG_LO:     return "LO";
            `ALU_REG_STATUS: return "STATUS";
            default:         return "UNMAPPED";
        endcase
    endfunction

    // Sampled in the access phase before the edge updates anything
    always @(posedge clk) begin
        if (reset && exp_valid && psel && penable) begin
            checks = checks + 1;
            if (pready !== 1'b1) begin
                errors = errors + 1;
                $display("[FAIL] %s pready: got %h, expected %h",
                         reg_name(paddr), pready, 1'b1);
            end
            if (pslverr !== exp_err) begin
                errors = errors + 1;
                $display("[FAIL] %s pslverr: got %h, expected %h",
                         reg_name(paddr), pslverr, exp_err);
            end
            if (!pwrite && prdata !== exp_data) begin
                errors = errors + 1;
                $display("[FAIL] %s prdata: got %h, expected %h",
                         reg_name(paddr), prdata, exp_data);
            end
        end
    end

endmodule

/* alu_core.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_core import alu_pkg::*; (
    exec_if.core x
);

    logic [`ALU_SHAMT_W-1:0] var_shamt;
    logic                    a_neg;
    logic                    a_is_zero;

    assign var_shamt = x.a[`ALU_SHAMT_W-1:0];     // Variable shifts use A[4:0]
    assign a_neg     = x.a[`ALU_DATA_W-1];
    assign a_is_zero = (x.a == '0);

    always_comb begin
        x.result = '0;                              // Also covers mult/div
        case (x.op)
            op_and:  x.result = x.a & x.b;
            op_or:   x.result = x.a | x.b;
            op_xor:  x.result = x.a ^ x.b;
            op_addu: x.result = x.a + x.b;
            op_subu: x.result = x.a - x.b;
            op_sltu: x.result = {{(`ALU_DATA_W-1){1'b0}}, (x.a < x.b)};
            op_slt:  x.result = {{(`ALU_DATA_W-1){1'b0}}, ($signed(x.a) < $signed(x.b))};
            op_sll:  x.result = x.b << x.shamt;
            op_sllv: x.result = x.b << var_shamt;
            op_sra:  x.result = $signed(x.b) >>> x.shamt;
            op_srl:  x.result = x.b >> x.shamt;
            op_srav: x.result = $signed(x.b) >>> var_shamt;
            op_srlv: x.result = x.b >> var_shamt;
            op_mfhi: x.result = x.hi;
            op_mflo: x.result = x.lo;

            // Branch tests give 0 when the condition holds
            op_bltz: begin
                if (a_neg) begin
                    x.result = '0;
                end else begin
                    x.result = 1;
                end
            end
            op_bgtz: begin
                if (!a_neg && !a_is_zero) begin
                    x.result = '0;
                end else begin
                    x.result = 1;
                end
            end
            op_bgez: begin
                if (!a_neg) begin
                    x.result = '0;
                end else begin
                    x.result = 1;
                end
            end
            op_bne: begin
                if (x.a != x.b) begin
                    x.result = '0;
                end else begin
                    x.result = 1;
                end
            end
            op_blez: begin
                if (a_neg || a_is_zero) begin
                    x.result = '0;
                end else begin
                    x.result = 1;
                end
            end

            op_jr:   x.result = x.a;                // Jump target passes through
            default: x.result = '0;                 // Unknown opcode
        endcase
    end

endmodule

/* alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Datapath widths
`define ALU_DATA_W      32
`define ALU_ADDR_W      8
`define ALU_SHAMT_W     5
`define ALU_OP_W        5

// Iterations per multiply or divide
`define MULDIV_STEPS    32

// APB register map
`define ALU_REG_OPA     8'h00
`define ALU_REG_OPB     8'h04
`define ALU_REG_CTRL    8'h08   // Opcode in 4:0, shamt in 12:8
`define ALU_REG_CMD     8'h0C   // Bit 0 starts an operation
`define ALU_REG_RESULT  8'h10
`define ALU_REG_HI      8'h14
`define ALU_REG_LO      8'h18
`define ALU_REG_STATUS  8'h1C   // Busy, zero, div_zero

`endif

/* alu_pkg.sv */
`include "alu_macros.svh"

package alu_pkg;

    // MIPS-style opcode encodings 0 to 24
    typedef enum logic [`ALU_OP_W-1:0] {
        op_and   = 5'd0,
        op_or    = 5'd1,
        op_xor   = 5'd2,
        op_addu  = 5'd3,
        op_subu  = 5'd4,
        op_sltu  = 5'd5,
        op_slt   = 5'd6,
        op_multu = 5'd7,    // HI:LO = A * B unsigned
        op_mult  = 5'd8,    // HI:LO = A * B signed
        op_sll   = 5'd9,
        op_sllv  = 5'd10,
        op_sra   = 5'd11,
        op_srl   = 5'd12,
        op_srav  = 5'd13,
        op_srlv  = 5'd14,
        op_div   = 5'd15,   // LO quotient, HI remainder
        op_divu  = 5'd16,
        op_mfhi  = 5'd17,
        op_mflo  = 5'd18,
        op_bltz  = 5'd19,   // Branch tests give 0 when taken
        op_bgtz  = 5'd20,
        op_bgez  = 5'd21,
        op_bne   = 5'd22,
        op_blez  = 5'd23,
        op_jr    = 5'd24
    } alu_op_e;

    // Multiply/divide sequencer
    typedef enum logic [1:0] {
        md_idle = 2'd0,
        md_run  = 2'd1,     // Load cycle then iterations
        md_fix  = 2'd2      // Sign correction and HI/LO write
    } muldiv_state_e;

endpackage

/* alu_regs.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_regs import alu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ALU_ADDR_W-1:0] paddr,
    input  logic [`ALU_DATA_W-1:0] pwdata,
    output logic [`ALU_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    exec_if.regs                   x
);

    logic                   wr_access;
    logic                   rd_access;
    logic                   addr_hit;
    logic                   is_cmd;
    logic                   unit_busy;
    logic                   go_accept;
    logic [`ALU_DATA_W-1:0] result_q;
    logic                   zero_q;
    logic [`ALU_DATA_W-1:0] ctrl_view;
    logic [`ALU_DATA_W-1:0] status_view;
    logic [`ALU_DATA_W-1:0] rd_mux;

    assign wr_access = psel & penable & pwrite;     // APB access phase
    assign rd_access = psel & penable & ~pwrite;
    assign is_cmd    = (paddr == `ALU_REG_CMD);

    // A go still in flight counts as busy
    assign unit_busy = x.busy | x.start;
    assign go_accept = wr_access & is_cmd & pwdata[0] & ~unit_busy;

    assign ctrl_view = {{(`ALU_DATA_W-8-`ALU_SHAMT_W){1'b0}}, x.shamt,
                        {(8-`ALU_OP_W){1'b0}}, x.op};
    assign status_view = {{(`ALU_DATA_W-3){1'b0}}, x.div_zero, zero_q, unit_busy};

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (paddr)
            `ALU_REG_OPA:    rd_mux = x.a;
            `ALU_REG_OPB:    rd_mux = x.b;
            `ALU_REG_CTRL:   rd_mux = ctrl_view;
            `ALU_REG_CMD:    rd_mux = '0;           // Write-only trigger
            `ALU_REG_RESULT: rd_mux = result_q;
            `ALU_REG_HI:     rd_mux = x.hi;
            `ALU_REG_LO:     rd_mux = x.lo;
            `ALU_REG_STATUS: rd_mux = status_view;
            default:         addr_hit = 1'b0;
        endcase
    end

    assign prdata  = rd_access ? rd_mux : '0;
    assign pready  = 1'b1;                          // No wait states
    assign pslverr = psel & penable & (~addr_hit | (pwrite & is_cmd & unit_busy));

    always_ff @(posedge clk) begin
        if (!reset) begin
            x.a      <= '0;
            x.b      <= '0;
            x.op     <= op_and;
            x.shamt  <= '0;
            x.start  <= 1'b0;
            result_q <= '0;
            zero_q   <= 1'b0;
        end else begin
            x.start <= go_accept;
            if (wr_access) begin
                case (paddr)
                    `ALU_REG_OPA: x.a <= pwdata;
                    `ALU_REG_OPB: x.b <= pwdata;
                    `ALU_REG_CTRL: begin
                        x.op    <= alu_op_e'(pwdata[`ALU_OP_W-1:0]);
                        x.shamt <= pwdata[8 +: `ALU_SHAMT_W];
                    end
                    default: ;                      // Read-only or CMD
                endcase
            end
            // Captured on every go, multiply and divide give zero
            if (x.start) begin
                result_q <= x.result;
                zero_q   <= (x.result == '0);
            end
        end
    end

endmodule

/* alu_top.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ALU_ADDR_W-1:0] paddr,
    input  logic [`ALU_DATA_W-1:0] pwdata,
    output logic [`ALU_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);

    exec_if exec_bus ();                    // Operands, start and HI/LO status

    alu_regs alu_regs_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .x       (exec_bus.regs)
    );

    alu_core alu_core_i (
        .x (exec_bus.core)
    );

    muldiv_unit muldiv_unit_i (
        .clk   (clk),
        .reset (reset),
        .x     (exec_bus.muldiv)
    );

endmodule

/* exec_if.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

interface exec_if import alu_pkg::*; ();

    logic [`ALU_DATA_W-1:0]  a;         // Operand A
    logic [`ALU_DATA_W-1:0]  b;         // Operand B
    logic [`ALU_SHAMT_W-1:0] shamt;
    alu_op_e                 op;
    logic                    start;     // One cycle per accepted go
    logic [`ALU_DATA_W-1:0]  hi;
    logic [`ALU_DATA_W-1:0]  lo;
    logic                    busy;      // Multiply or divide in progress
    logic                    div_zero;  // Sticky until next go
    logic [`ALU_DATA_W-1:0]  result;    // Single-cycle result

    modport regs (
        output a, b, shamt, op, start,
        input  hi, lo, busy, div_zero, result
    );

    modport core (
        input  a, b, shamt, op, hi, lo,
        output result
    );

    modport muldiv (
        input  a, b, op, start,
        output hi, lo, busy, div_zero
    );

endinterface

/* muldiv_unit.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module muldiv_unit import alu_pkg::*; (
    input logic     clk,
    input logic     reset,
    exec_if.muldiv  x
);

    localparam int W     = `ALU_DATA_W;
    localparam int CNT_W = $clog2(`MULDIV_STEPS + 1);

    muldiv_state_e  state;
    logic [CNT_W-1:0] step;                 // 0 is the load cycle
    logic [2*W-1:0] acc;                    // Upper and lower working halves
    logic [W-1:0]   mag_a;
    logic [W-1:0]   mag_b;
    logic           is_div;
    logic           neg_a;
    logic           neg_b;
    logic           md_op;
    logic           md_signed;
    logic [W:0]     add_sum;
    logic [W:0]     rem_sh;
    logic [W:0]     rem_diff;
    logic [2*W-1:0] prod_fixed;
    logic [W-1:0]   quo_fixed;
    logic [W-1:0]   rem_fixed;

    always_comb begin
        md_op     = 1'b0;
        md_signed = 1'b0;
        case (x.op)
            op_mult, op_div: begin
                md_op     = 1'b1;
                md_signed = 1'b1;
            end
            op_multu, op_divu: md_op = 1'b1;
            default: ;
        endcase
    end

    assign x.busy = (state != md_idle);

    assign add_sum  = {1'b0, acc[2*W-1:W]} + {1'b0, mag_b};  // Shift-add partial
    assign rem_sh   = acc[2*W-1:W-1];                          // Remainder shifted in
    assign rem_diff = rem_sh - {1'b0, mag_b};

    // Quotient follows sign of A xor B, remainder follows A
    always_comb begin
        prod_fixed = acc;
        quo_fixed  = acc[W-1:0];
        rem_fixed  = acc[2*W-1:W];
        if (neg_a ^ neg_b) begin
            prod_fixed = -acc;
            quo_fixed  = -acc[W-1:0];
        end
        if (neg_a) begin
            rem_fixed = -acc[2*W-1:W];
        end
    end

    always_ff @(posedge clk) begin
        if (state == md_idle && x.start) begin
            neg_a  <= md_signed & x.a[W-1];
            neg_b  <= md_signed & x.b[W-1];
            mag_a  <= (md_signed && x.a[W-1]) ? -x.a : x.a;
            mag_b  <= (md_signed && x.b[W-1]) ? -x.b : x.b;
            is_div <= (x.op == op_div) || (x.op == op_divu);
        end
        if (state == md_run) begin
            if (step == '0) begin
                acc <= {{W{1'b0}}, mag_a};
            end else if (is_div) begin
                if (!rem_diff[W]) begin
                    acc <= {rem_diff[W-1:0], acc[W-2:0], 1'b1};
                end else begin
                    acc <= {rem_sh[W-1:0], acc[W-2:0], 1'b0};
                end
            end else if (acc[0]) begin
                acc <= {add_sum, acc[W-1:1]};
            end else begin
                acc <= {1'b0, acc[2*W-1:1]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= md_idle;
            step       <= '0;
            x.hi       <= '0;
            x.lo       <= '0;
            x.div_zero <= 1'b0;
        end else begin
            case (state)
                md_idle: begin
                    if (x.start) begin
                        x.div_zero <= 1'b0;             // Any go clears it
                        step       <= '0;
                        if (md_op) begin
                            state <= md_run;
                        end
                    end
                end
                md_run: begin
                    step <= step + 1'b1;
                    if (step == '0 && is_div && mag_b == '0) begin
                        x.div_zero <= 1'b1;             // HI and LO kept
                        state      <= md_idle;
                    end else if (step == CNT_W'(`MULDIV_STEPS)) begin
                        state <= md_fix;
                    end
                end
                md_fix: begin
                    state <= md_idle;
                    if (is_div) begin
                        x.hi <= rem_fixed;
                        x.lo <= quo_fixed;
                    end else begin
                        x.hi <= prod_fixed[2*W-1:W];
                        x.lo <= prod_fixed[W-1:0];
                    end
                end
                default: state <= md_idle;
            endcase
        end
    end

endmodule

/* tb.f */
+incdir+.
alu_pkg.sv
exec_if.sv
alu_regs.sv
alu_core.sv
muldiv_unit.sv
alu_top.sv
alu_checker.sv
tb_alu_top.sv

/* tb_alu_top.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_alu_top import alu_pkg::*; ();

    typedef struct packed {
        logic [4:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  shamt;
        logic [31:0] result;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        dz;
    } test_t;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        exp_valid;
    logic [31:0] exp_data;
    logic        exp_err;
    int          checks;
    int          errors;
    int          exp_checks;
    int          cycles;
    int          timeout_limit;
    test_t       tests[$];

    alu_top alu_top_i (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    alu_checker alu_checker_i (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .exp_valid(exp_valid), .exp_data(exp_data), .exp_err(exp_err),
        .checks(checks), .errors(errors)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic add_test(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
                            input logic [4:0] shamt, input logic [31:0] result,
                            input logic [31:0] hi, input logic [31:0] lo, input logic dz);
        tests.push_back({op, a, b, shamt, result, hi, lo, dz});
    endtask

    // Setup phase then access phase with no wait states
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                input logic chk, input logic [31:0] exp, input logic exp_e,
                                output logic [31:0] rdata);
        @(posedge clk);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= wr;
        paddr     <= addr;
        pwdata    <= wdata;
        exp_valid <= chk;
        exp_data  <= exp;
        exp_err   <= exp_e;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        rdata = prdata;
        psel      <= 1'b0;
        penable   <= 1'b0;
        exp_valid <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, 1'b0, 0, 1'b0, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input logic exp_e);
        logic [31:0] unused;
        apb_transfer(1'b0, addr, 0, 1'b1, exp, exp_e, unused);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        status = 32'd1;
        while (status[0]) begin
            apb_transfer(1'b0, `ALU_REG_STATUS, 0, 1'b0, 0, 1'b0, status);
        end
    endtask

    task automatic run_entry(input test_t t);
        logic [31:0] exp_status;
        exp_status = {29'd0, t.dz, (t.result == 32'd0), 1'b0};
        apb_write(`ALU_REG_OPA, t.a);
        apb_write(`ALU_REG_OPB, t.b);
        apb_write(`ALU_REG_CTRL, {19'd0, t.shamt, 3'd0, t.op});
        apb_write(`ALU_REG_CMD, 32'd1);
        wait_idle();
        apb_read(`ALU_REG_RESULT, t.result, 1'b0);
        apb_read(`ALU_REG_HI, t.hi, 1'b0);
        apb_read(`ALU_REG_LO, t.lo, 1'b0);
        apb_read(`ALU_REG_STATUS, exp_status, 1'b0);
    endtask

    // A go during a divide is refused and OPB changes do not reach it
    task automatic check_busy_go();
        logic [31:0] unused;
        apb_write(`ALU_REG_OPA, 32'd1000);
        apb_write(`ALU_REG_OPB, 32'd33);
        apb_write(`ALU_REG_CTRL, {27'd0, op_divu});
        apb_write(`ALU_REG_CMD, 32'd1);
        apb_write(`ALU_REG_OPB, 32'd3);
        apb_transfer(1'b1, `ALU_REG_CMD, 32'd1, 1'b1, 0, 1'b1, unused);
        wait_idle();
        apb_read(`ALU_REG_HI, 32'd10, 1'b0);
        apb_read(`ALU_REG_LO, 32'd30, 1'b0);
        apb_read(`ALU_REG_STATUS, 32'h2, 1'b0);
    endtask

    task automatic fill_table();
        add_test(op_and,  32'hf0f000ff, 32'h0ff00f0f, 5'd0, 32'h00f0000f, 0, 0, 1'b0);
        add_test(op_or,   32'hf0000000, 32'h0000000f, 5'd0, 32'hf000000f, 0, 0, 1'b0);
        add_test(op_xor,  32'haaaa5555, 32'haaaa5555, 5'd0, 0, 0, 0, 1'b0);
        add_test(op_addu, 32'hffffffff, 32'h00000002, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_subu, 32'h00000000, 32'h00000001, 5'd0, 32'hffffffff, 0, 0, 1'b0);
        add_test(op_sltu, 32'hfffffffe, 32'h00000001, 5'd0, 0, 0, 0, 1'b0);
        add_test(op_slt,  32'hfffffffe, 32'h00000001, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_sltu, 32'h00000001, 32'h80000000, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_slt,  32'h00000001, 32'h80000000, 5'd0, 0, 0, 0, 1'b0);
        add_test(op_bltz, 32'h80000000, 0, 5'd0, 0, 0, 0, 1'b0);         // Taken gives 0
        add_test(op_bltz, 32'h00000000, 0, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_bgtz, 32'h00000005, 0, 5'd0, 0, 0, 0, 1'b0);
        add_test(op_bgtz, 32'h00000000, 0, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_bgez, 32'h00000000, 0, 5'd0, 0, 0, 0, 1'b0);
        add_test(op_bgez, 32'hfffffff0, 0, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_blez, 32'hffffffff, 0, 5'd0, 0, 0, 0, 1'b0);
        add_test(op_blez, 32'h00000007, 0, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_bne,  32'h00000003, 32'h00000004, 5'd0, 0, 0, 0, 1'b0);
        add_test(op_bne,  32'h00000009, 32'h00000009, 5'd0, 32'h00000001, 0, 0, 1'b0);
        add_test(op_jr,   32'h00401000, 0, 5'd0, 32'h00401000, 0, 0, 1'b0);
        add_test(op_sll,  0, 32'h00000001, 5'd31, 32'h80000000, 0, 0, 1'b0);
        add_test(op_srl,  0, 32'h80000000, 5'd4, 32'h08000000, 0, 0, 1'b0);
        add_test(op_sra,  0, 32'h80000000, 5'd4, 32'hf8000000, 0, 0, 1'b0);
        add_test(op_sllv, 32'h00000024, 32'h000000f0, 5'd0, 32'h00000f00, 0, 0, 1'b0);
        add_test(op_srlv, 32'hffffffe8, 32'hf0000000, 5'd0, 32'h00f00000, 0, 0, 1'b0);
        add_test(op_srav, 32'hffffffe8, 32'hf0000000, 5'd0, 32'hfff00000, 0, 0, 1'b0);
        add_test(op_multu, 32'hffffffff, 32'hffffffff, 5'd0, 0, 32'hfffffffe, 32'h1, 1'b0);
        add_test(op_mult, 32'hffffffff, 32'hffffffff, 5'd0, 0, 0, 32'h1, 1'b0);
        add_test(op_mult, 32'h7fffffff, 32'h00000002, 5'd0, 0, 0, 32'hfffffffe, 1'b0);
        add_test(op_mult, 32'h00010000, 32'hfffe0000, 5'd0, 0, 32'hfffffffe, 0, 1'b0);
        add_test(op_mult, 32'hfffffffd, 32'h00000007, 5'd0, 0, 32'hffffffff, 32'hffffffeb, 1'b0);
        add_test(op_mfhi, 0, 0, 5'd0, 32'hffffffff, 32'hffffffff, 32'hffffffeb, 1'b0);
        add_test(op_mflo, 0, 0, 5'd0, 32'hffffffeb, 32'hffffffff, 32'hffffffeb, 1'b0);
        add_test(op_divu, 32'h00000064, 32'h00000007, 5'd0, 0, 32'h2, 32'he, 1'b0);
        add_test(op_divu, 32'hfffffff9, 32'h00000002, 5'd0, 0, 32'h1, 32'h7ffffffc, 1'b0);
        add_test(op_div, 32'hfffffff9, 32'h00000002, 5'd0, 0, 32'hffffffff, 32'hfffffffd, 1'b0);
        add_test(op_div, 32'h00000007, 32'hfffffffe, 5'd0, 0, 32'h1, 32'hfffffffd, 1'b0);
        add_test(op_div, 32'hfffffff9, 32'hfffffffe, 5'd0, 0, 32'hffffffff, 32'h3, 1'b0);
        add_test(op_div, 32'h00000005, 0, 5'd0, 0, 32'hffffffff, 32'h3, 1'b1);   // HI, LO kept
        add_test(op_addu, 32'h1, 32'h1, 5'd0, 32'h2, 32'hffffffff, 32'h3, 1'b0);
        add_test(5'd25, 32'hffffffff, 32'h1, 5'd0, 0, 32'hffffffff, 32'h3, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_err   = 1'b0;
        fill_table();
        timeout_limit = tests.size() * 60 + 200;
        exp_checks    = tests.size() * 4 + 13;     // Reset reads, unmapped, table, busy go
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            apb_read(8'(i * 4), 0, 1'b0);       // All registers clear
        end
        apb_read(8'h20, 0, 1'b1);
        foreach (tests[i]) begin
            run_entry(tests[i]);
        end
        check_busy_go();
        @(posedge clk);
        if (checks != exp_checks) begin
            $display("Checker compared %0d transfers instead of %0d", checks, exp_checks);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks == exp_checks) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
